/* alu/alu.sv */
`timescale 1ns/1ps
`default_nettype none
`include "exec_config.svh"

module alu (
    input  wire  [`EXEC_XLEN-1:0] op_a_i,
    input  wire  [`EXEC_XLEN-1:0] op_b_i,
    input  wire  exec_pkg::alu_op_e op_i,
    output logic [`EXEC_XLEN-1:0] result_o,
    output logic                  illegal_o
);

    localparam int HALF = `EXEC_XLEN / 2;

    logic [`EXEC_XLEN-1:0] add_result;
    logic [`EXEC_XLEN-1:0] shift_result;
    logic [`EXEC_XLEN-1:0] logic_result;
    logic [`EXEC_XLEN-1:0] unit_result;   // Selected unit, before W extension
    logic                  is_word;

    alu_add alu_add_inst (
        .data_rs1_i (op_a_i),
        .data_rs2_i (op_b_i),
        .op_i       (op_i),
        .result_o   (add_result)
    );

    alu_shift alu_shift_inst (
        .data_rs1_i (op_a_i),
        .data_rs2_i (op_b_i),
        .op_i       (op_i),
        .result_o   (shift_result)
    );

    alu_logic_cmp alu_logic_cmp_inst (
        .data_rs1_i (op_a_i),
        .data_rs2_i (op_b_i),
        .op_i       (op_i),
        .result_o   (logic_result)
    );

    // ----------------------------------------
    // Unit select by operation class
    // ----------------------------------------
    always_comb begin
        illegal_o = 1'b0;
        case (op_i)
            exec_pkg::OP_ADD, exec_pkg::OP_SUB,
            exec_pkg::OP_ADDW, exec_pkg::OP_SUBW: unit_result = add_result;
            exec_pkg::OP_SLL, exec_pkg::OP_SLLW, exec_pkg::OP_SRL,
            exec_pkg::OP_SRLW, exec_pkg::OP_SRA, exec_pkg::OP_SRAW: unit_result = shift_result;
            exec_pkg::OP_SLT, exec_pkg::OP_SLTU, exec_pkg::OP_AND,
            exec_pkg::OP_OR, exec_pkg::OP_XOR: unit_result = logic_result;
            default: begin
                unit_result = '0;    // Unassigned opcode
                illegal_o   = 1'b1;
            end
        endcase
    end

    assign is_word = op_i inside {exec_pkg::OP_ADDW, exec_pkg::OP_SUBW, exec_pkg::OP_SLLW,
                                  exec_pkg::OP_SRLW, exec_pkg::OP_SRAW};

    // W forms take bit 31 as the sign
    assign result_o = is_word ? {{HALF{unit_result[HALF-1]}}, unit_result[HALF-1:0]}
                              : unit_result;

endmodule

`default_nettype wire

/* alu/alu_add.sv */
`timescale 1ns/1ps
`default_nettype none
`include "exec_config.svh"

module alu_add (
    input  wire  [`EXEC_XLEN-1:0] data_rs1_i,
    input  wire  [`EXEC_XLEN-1:0] data_rs2_i,
    input  wire  exec_pkg::alu_op_e op_i,
    output logic [`EXEC_XLEN-1:0] result_o
);

    logic                  sub;
    logic [`EXEC_XLEN-1:0] operand_b;
    logic [`EXEC_XLEN-1:0] sum;      // Carry out falls off the top

    assign sub = (op_i == exec_pkg::OP_SUB) || (op_i == exec_pkg::OP_SUBW);

    // Subtract as rs1 + ~rs2 + 1
    assign operand_b = sub ? ~data_rs2_i : data_rs2_i;

    always_comb begin
        sum = data_rs1_i + operand_b + {{(`EXEC_XLEN-1){1'b0}}, sub};
    end

    // W extension happens in alu
    assign result_o = sum;

endmodule

`default_nettype wire

/* alu/alu_logic_cmp.sv */
`timescale 1ns/1ps
`default_nettype none
`include "exec_config.svh"

module alu_logic_cmp (
    input  wire  [`EXEC_XLEN-1:0] data_rs1_i,
    input  wire  [`EXEC_XLEN-1:0] data_rs2_i,
    input  wire  exec_pkg::alu_op_e op_i,
    output logic [`EXEC_XLEN-1:0] result_o
);

    logic lt_signed;
    logic lt_unsigned;

    assign lt_signed   = $signed(data_rs1_i) < $signed(data_rs2_i);
    assign lt_unsigned = data_rs1_i < data_rs2_i;

    always_comb begin
        case (op_i)
            exec_pkg::OP_AND:  result_o = data_rs1_i & data_rs2_i;
            exec_pkg::OP_OR:   result_o = data_rs1_i | data_rs2_i;
            exec_pkg::OP_XOR:  result_o = data_rs1_i ^ data_rs2_i;
            // Compare result in bit 0 only
            exec_pkg::OP_SLT:  result_o = {{(`EXEC_XLEN-1){1'b0}}, lt_signed};
            exec_pkg::OP_SLTU: result_o = {{(`EXEC_XLEN-1){1'b0}}, lt_unsigned};
            default:           result_o = '0;
        endcase
    end

endmodule

`default_nettype wire

/* alu/alu_shift.sv */
`timescale 1ns/1ps
`default_nettype none
`include "exec_config.svh"

module alu_shift (
    input  wire  [`EXEC_XLEN-1:0] data_rs1_i,
    input  wire  [`EXEC_XLEN-1:0] data_rs2_i,
    input  wire  exec_pkg::alu_op_e op_i,
    output logic [`EXEC_XLEN-1:0] result_o
);

    localparam int HALF  = `EXEC_XLEN / 2;
    localparam int SH_W  = $clog2(`EXEC_XLEN);

    logic                  is_word;
    logic [SH_W-1:0]       shamt;
    logic [`EXEC_XLEN-1:0] lo_zext;      // Low word, zero filled
    logic [`EXEC_XLEN-1:0] lo_sext;      // Low word, sign filled from bit 31

    assign is_word = op_i inside {exec_pkg::OP_SLLW, exec_pkg::OP_SRLW, exec_pkg::OP_SRAW};

    // Word forms use 5 amount bits
    assign shamt = is_word ? {1'b0, data_rs2_i[SH_W-2:0]} : data_rs2_i[SH_W-1:0];

    assign lo_zext = {{HALF{1'b0}}, data_rs1_i[HALF-1:0]};
    assign lo_sext = {{HALF{data_rs1_i[HALF-1]}}, data_rs1_i[HALF-1:0]};

    // ----------------------------------------
    // Shift select
    // ----------------------------------------
    always_comb begin
        case (op_i)
            exec_pkg::OP_SLL,
            exec_pkg::OP_SLLW: begin
                result_o = data_rs1_i << shamt;    // Upper half ignored for SLLW
            end
            exec_pkg::OP_SRL: begin
                result_o = data_rs1_i >> shamt;
            end
            exec_pkg::OP_SRLW: begin
                result_o = lo_zext >> shamt;
            end
            exec_pkg::OP_SRA: begin
                result_o = $signed(data_rs1_i) >>> shamt;
            end
            exec_pkg::OP_SRAW: begin
                result_o = $signed(lo_sext) >>> shamt;
            end
            default: begin
                result_o = '0;
            end
        endcase
    end

endmodule

`default_nettype wire

/* bench/int_exec_cases.txt */
# opcode rs1 rs2 expected_result expected_illegal, all fields hex
# opcodes: 0 ADD 1 SUB 2 ADDW 3 SUBW 4 SLL 5 SLLW 6 SRL 7 SRLW 8 SRA 9 SRAW a SLT b SLTU c AND d OR e XOR
0 0000000000000005 0000000000000007 000000000000000c 0
0 ffffffffffffffff 0000000000000001 0000000000000000 0
0 7fffffffffffffff 0000000000000001 8000000000000000 0
1 0000000000000000 0000000000000001 ffffffffffffffff 0
1 123456789abcdef0 0fedcba987654321 02468acf13579bcf 0
2 000000007fffffff 0000000000000001 ffffffff80000000 0
3 0000000000000000 0000000000000001 ffffffffffffffff 0
3 0000000100000005 0000000000000003 0000000000000002 0
4 0000000000000001 000000000000003f 8000000000000000 0
4 0000000000000001 0000000000000041 0000000000000002 0
5 0000000000000001 000000000000001f ffffffff80000000 0
5 0000000000000001 0000000000000021 0000000000000002 0
6 8000000000000000 000000000000003f 0000000000000001 0
7 ffffffff80000000 000000000000001f 0000000000000001 0
7 0000000080000000 0000000000000000 ffffffff80000000 0
8 8000000000000000 0000000000000004 f800000000000000 0
8 8000000000000000 0000000000000044 f800000000000000 0
9 0000000080000000 0000000000000004 fffffffff8000000 0
9 000000007ffffff0 0000000000000024 0000000007ffffff 0
a 8000000000000000 0000000000000001 0000000000000001 0
b 8000000000000000 0000000000000001 0000000000000000 0
a 0000000000000005 0000000000000005 0000000000000000 0
b 0000000000000001 ffffffffffffffff 0000000000000001 0
c f0f0f0f0f0f0f0f0 ff00ff00ff00ff00 f000f000f000f000 0
d f0f0f0f0f0f0f0f0 0f0f0f0f00000000 fffffffff0f0f0f0 0
e aaaaaaaaaaaaaaaa ffffffffffffffff 5555555555555555 0
f 0000000000000001 0000000000000002 0000000000000000 1
0 0000000000000001 0000000000000001 0000000000000002 0

/* bench/tb_int_exec_unit.sv */
`timescale 1ns/1ps
`default_nettype none
`include "exec_config.svh"

module tb_int_exec_unit;

    localparam int CLK_PERIOD      = 100;
    localparam int RESET_CYCLES    = 8;
    localparam int RANDOM_CASES    = 200;
    localparam int CYCLES_PER_CASE = 20;
    localparam int ACK_LIMIT       = 10;    // Cycles to wait for ack

    logic                   clk_i;
    logic                   rst_n_i;
    logic                   wb_cyc_i;
    logic                   wb_stb_i;
    logic                   wb_we_i;
    logic [`EXEC_ADR_W-1:0] wb_adr_i;
    logic [`EXEC_XLEN-1:0]  wb_dat_i;
    logic [`EXEC_XLEN-1:0]  wb_dat_o;
    logic                   wb_ack_o;

    int errors;
    int tests_run;
    int tests_failed;
    int seed;
    bit cases_loaded;

    // Directed cases from the data file
    logic [3:0]            case_op[$];
    logic [`EXEC_XLEN-1:0] case_a[$];
    logic [`EXEC_XLEN-1:0] case_b[$];
    logic [`EXEC_XLEN-1:0] case_res[$];
    logic                  case_ill[$];

    int_exec_unit int_exec_unit_inst (
        .clk_i    (clk_i),
        .rst_n_i  (rst_n_i),
        .wb_cyc_i (wb_cyc_i),
        .wb_stb_i (wb_stb_i),
        .wb_we_i  (wb_we_i),
        .wb_adr_i (wb_adr_i),
        .wb_dat_i (wb_dat_i),
        .wb_dat_o (wb_dat_o),
        .wb_ack_o (wb_ack_o)
    );

    always #(CLK_PERIOD / 2) clk_i = ~clk_i;

    // ----------------------------------------
    // RV64 reference model
    // ----------------------------------------
    function automatic logic [`EXEC_XLEN-1:0] sext_word(input logic [31:0] w);
        return {{(`EXEC_XLEN-32){w[31]}}, w};
    endfunction

    function automatic logic [`EXEC_XLEN-1:0] alu_model(input logic [3:0] op,
            input logic [`EXEC_XLEN-1:0] a, input logic [`EXEC_XLEN-1:0] b,
            output logic illegal);
        logic [`EXEC_XLEN-1:0]        r;
        logic signed [`EXEC_XLEN-1:0] sa;
        logic signed [31:0]           sw;
        illegal = 1'b0;
        r  = '0;
        sa = $signed(a);
        sw = $signed(a[31:0]);
        case (op)
            exec_pkg::OP_ADD:  r = a + b;
            exec_pkg::OP_SUB:  r = a - b;
            exec_pkg::OP_ADDW: r = sext_word(a[31:0] + b[31:0]);
            exec_pkg::OP_SUBW: r = sext_word(a[31:0] - b[31:0]);
            exec_pkg::OP_SLL:  r = a << b[5:0];
            exec_pkg::OP_SLLW: r = sext_word(a[31:0] << b[4:0]);
            exec_pkg::OP_SRL:  r = a >> b[5:0];
            exec_pkg::OP_SRLW: r = sext_word(a[31:0] >> b[4:0]);
            exec_pkg::OP_SRA:  r = sa >>> b[5:0];
            exec_pkg::OP_SRAW: r = sext_word(sw >>> b[4:0]);
            exec_pkg::OP_SLT:  r = {{(`EXEC_XLEN-1){1'b0}}, sa < $signed(b)};
            exec_pkg::OP_SLTU: r = {{(`EXEC_XLEN-1){1'b0}}, a < b};
            exec_pkg::OP_AND:  r = a & b;
            exec_pkg::OP_OR:   r = a | b;
            exec_pkg::OP_XOR:  r = a ^ b;
            default:           illegal = 1'b1;    // Code 15
        endcase
        return r;
    endfunction

    function automatic logic [`EXEC_XLEN-1:0] status_word(input logic done, input logic illegal);
        logic [`EXEC_XLEN-1:0] w;
        w = '0;
        w[exec_pkg::STAT_DONE_BIT]    = done;
        w[exec_pkg::STAT_ILLEGAL_BIT] = illegal;
        return w;
    endfunction

    // ----------------------------------------
    // Checks and bus access
    // ----------------------------------------
    task automatic check_value(input string name, input logic [`EXEC_XLEN-1:0] got,
            input logic [`EXEC_XLEN-1:0] exp);
        assert (got === exp) else begin
            $display("ERROR at %0d ns: %s expected %h, got %h", $time, name, exp, got);
            errors++;
        end
    endtask

    task automatic end_test(input string label, input int err_before);
        tests_run++;
        if (errors == err_before) begin
            $display("PASS %s", label);
        end else begin
            tests_failed++;
            $display("FAIL %s", label);
        end
    endtask

    // One classic cycle, inputs change on the falling edge only
    task automatic access_bus(input logic we, input logic [`EXEC_ADR_W-1:0] adr,
            input logic [`EXEC_XLEN-1:0] wdata, output logic [`EXEC_XLEN-1:0] rdata);
        int waited;
        @(negedge clk_i);
        wb_cyc_i = 1'b1;
        wb_stb_i = 1'b1;
        wb_we_i  = we;
        wb_adr_i = adr;
        wb_dat_i = wdata;
        @(negedge clk_i);
        waited = 1;
        while (!wb_ack_o && waited < ACK_LIMIT) begin
            @(negedge clk_i);
            waited++;
        end
        assert (wb_ack_o) else begin
            $display("No ack within %0d cycles for access to address 0x%h", ACK_LIMIT, adr);
            errors++;
        end
        rdata    = wb_dat_o;
        wb_cyc_i = 1'b0;
        wb_stb_i = 1'b0;
        wb_we_i  = 1'b0;
        @(negedge clk_i);    // Also the idle cycle between accesses
        assert (!wb_ack_o) else begin
            $display("Second ack seen for one access to address 0x%h", adr);
            errors++;
        end
    endtask

    task automatic write_reg(input logic [`EXEC_ADR_W-1:0] adr, input logic [`EXEC_XLEN-1:0] d);
        logic [`EXEC_XLEN-1:0] ignored;
        access_bus(1'b1, adr, d, ignored);
    endtask

    task automatic expect_reg(input string name, input logic [`EXEC_ADR_W-1:0] adr,
            input logic [`EXEC_XLEN-1:0] exp);
        logic [`EXEC_XLEN-1:0] rd;
        access_bus(1'b0, adr, '0, rd);
        check_value(name, rd, exp);
    endtask

    task automatic run_alu_case(input string label, input logic [3:0] op,
            input logic [`EXEC_XLEN-1:0] a, input logic [`EXEC_XLEN-1:0] b,
            input logic [`EXEC_XLEN-1:0] exp_res, input logic exp_ill);
        int err_before;
        err_before = errors;
        write_reg(`EXEC_REG_RS1, a);
        write_reg(`EXEC_REG_RS2, b);
        write_reg(`EXEC_REG_CMD, {{(`EXEC_XLEN-4){1'b0}}, op});
        expect_reg("STATUS", `EXEC_REG_STATUS, status_word(1'b1, exp_ill));
        expect_reg("RESULT", `EXEC_REG_RESULT, exp_res);
        end_test(label, err_before);
    endtask

    task automatic load_cases();
        int                    fd;
        int                    n;
        string                 line;
        logic [3:0]            op;
        logic [`EXEC_XLEN-1:0] a;
        logic [`EXEC_XLEN-1:0] b;
        logic [`EXEC_XLEN-1:0] res;
        logic                  ill;
        fd = $fopen("bench/int_exec_cases.txt", "r");
        assert (fd != 0) else begin
            $display("Could not open bench/int_exec_cases.txt");
            errors++;
        end
        if (fd != 0) begin
            while ($fgets(line, fd) != 0) begin
                if (line.len() < 2 || line.getc(0) == "#") continue;    // Blank or comment
                n = $sscanf(line, "%h %h %h %h %h", op, a, b, res, ill);
                assert (n == 5) else begin
                    $display("Malformed line in cases file: %s", line);
                    errors++;
                end
                if (n == 5) begin
                    case_op.push_back(op);
                    case_a.push_back(a);
                    case_b.push_back(b);
                    case_res.push_back(res);
                    case_ill.push_back(ill);
                end
            end
            $fclose(fd);
        end
    endtask

    // ----------------------------------------
    // Test sequence
    // ----------------------------------------
    initial begin
        logic [`EXEC_XLEN-1:0]  a;
        logic [`EXEC_XLEN-1:0]  b;
        logic [`EXEC_XLEN-1:0]  exp;
        logic [31:0]            rnd;
        logic [3:0]             op;
        logic                   ill;
        int                     err_before;
        logic [`EXEC_ADR_W-1:0] unmapped [4];
        clk_i    = 1'b0;
        rst_n_i  = 1'b0;
        wb_cyc_i = 1'b0;
        wb_stb_i = 1'b0;
        wb_we_i  = 1'b0;
        wb_adr_i = '0;
        wb_dat_i = '0;
        errors       = 0;
        tests_run    = 0;
        tests_failed = 0;
        seed         = 32'h4f78;
        load_cases();
        cases_loaded = 1'b1;
        repeat (RESET_CYCLES) @(negedge clk_i);
        rst_n_i = 1'b1;

        err_before = errors;
        repeat (3) begin
            @(negedge clk_i);
            assert (!wb_ack_o) else begin
                $display("ERROR at %0d ns: wb_ack_o expected 0, got 1", $time);
                errors++;
            end
        end
        expect_reg("STATUS", `EXEC_REG_STATUS, '0);
        expect_reg("RESULT", `EXEC_REG_RESULT, '0);
        expect_reg("RS1", `EXEC_REG_RS1, '0);
        expect_reg("RS2", `EXEC_REG_RS2, '0);
        end_test("reset state", err_before);

        for (int i = 0; i < case_op.size(); i++) begin
            run_alu_case($sformatf("case %0d op %0d", i, case_op[i]), case_op[i],
                         case_a[i], case_b[i], case_res[i], case_ill[i]);
        end

        // Done clear on STATUS write, illegal flag set and cleared
        err_before = errors;
        write_reg(`EXEC_REG_CMD, 64'hf);
        expect_reg("STATUS", `EXEC_REG_STATUS, status_word(1'b1, 1'b1));
        expect_reg("RESULT", `EXEC_REG_RESULT, '0);
        write_reg(`EXEC_REG_STATUS, '0);
        expect_reg("STATUS", `EXEC_REG_STATUS, status_word(1'b0, 1'b1));
        write_reg(`EXEC_REG_CMD, {{(`EXEC_XLEN-4){1'b0}}, exec_pkg::OP_XOR});
        expect_reg("STATUS", `EXEC_REG_STATUS, status_word(1'b1, 1'b0));
        end_test("status behavior", err_before);

        err_before = errors;
        unmapped = '{6'h04, 6'h28, 6'h30, 6'h38};
        write_reg(`EXEC_REG_RS1, 64'h0123456789abcdef);
        write_reg(`EXEC_REG_RS2, 64'hfedcba9876543210);
        write_reg(`EXEC_REG_CMD, 64'hfffffffffffffffd);    // Upper bits dropped, OR
        foreach (unmapped[i]) write_reg(unmapped[i], 64'h5a5a5a5a5a5a5a5a);
        foreach (unmapped[i]) expect_reg("unmapped read", unmapped[i], '0);
        expect_reg("RS1", `EXEC_REG_RS1, 64'h0123456789abcdef);
        expect_reg("RS2", `EXEC_REG_RS2, 64'hfedcba9876543210);
        expect_reg("CMD", `EXEC_REG_CMD, 64'hd);
        expect_reg("RESULT", `EXEC_REG_RESULT, 64'hffffffffffffffff);
        end_test("bus behavior", err_before);

        for (int i = 0; i < RANDOM_CASES; i++) begin
            rnd = $random(seed);
            op  = rnd[3:0];
            a[63:32] = $random(seed);
            a[31:0]  = $random(seed);
            b[63:32] = $random(seed);
            b[31:0]  = $random(seed);
            exp = alu_model(op, a, b, ill);
            run_alu_case($sformatf("random %0d op %0d", i, op), op, a, b, exp, ill);
        end

        $display("Tests run: %0d, failed: %0d, check errors: %0d",
                 tests_run, tests_failed, errors);
        if (errors == 0) begin
            $display("Testbench passed");
        end else begin
            $display("Testbench failed");
        end
        $finish;
    end

    // Watchdog sized from the case count
    initial begin
        int limit_ns;
        wait (cases_loaded);
        limit_ns = (case_op.size() + RANDOM_CASES) * CYCLES_PER_CASE * CLK_PERIOD
                   + RESET_CYCLES * CLK_PERIOD;
        #(limit_ns);
        $display("Timeout: the run did not finish within %0d ns", limit_ns);
        $display("Testbench failed");
        $finish;
    end

endmodule

`default_nettype wire

/* common/exec_config.svh */
`ifndef EXEC_CONFIG_SVH
`define EXEC_CONFIG_SVH

// Datapath width
`define EXEC_XLEN 64

// Byte address bits on the bus, 8-byte words
`define EXEC_ADR_W 6

// ----------------------------------------
// Register map, byte offsets
// ----------------------------------------
`define EXEC_REG_RS1    6'h00
`define EXEC_REG_RS2    6'h08
`define EXEC_REG_CMD    6'h10
`define EXEC_REG_STATUS 6'h18
`define EXEC_REG_RESULT 6'h20

`endif

/* common/exec_pkg.sv */
`default_nettype none

package exec_pkg;

    // ----------------------------------------
    // ALU operations
    // ----------------------------------------
    // Code 15 has no member and decodes as illegal
    typedef enum logic [3:0] {
        OP_ADD  = 4'd0,
        OP_SUB  = 4'd1,
        OP_ADDW = 4'd2,
        OP_SUBW = 4'd3,
        OP_SLL  = 4'd4,
        OP_SLLW = 4'd5,
        OP_SRL  = 4'd6,
        OP_SRLW = 4'd7,
        OP_SRA  = 4'd8,
        OP_SRAW = 4'd9,
        OP_SLT  = 4'd10,
        OP_SLTU = 4'd11,
        OP_AND  = 4'd12,
        OP_OR   = 4'd13,
        OP_XOR  = 4'd14
    } alu_op_e;

    // ----------------------------------------
    // Controller FSM
    // ----------------------------------------
    typedef enum logic {
        ST_IDLE = 1'b0,     // Waiting for a CMD write
        ST_EXEC = 1'b1      // ALU result captured at the end of this cycle
    } ctrl_state_e;

    // Status register layout
    localparam int unsigned STAT_DONE_BIT    = 0;
    localparam int unsigned STAT_ILLEGAL_BIT = 1;

endpackage

`default_nettype wire

/* int_exec_unit.f */
+incdir+common
common/exec_pkg.sv
alu/alu_add.sv
alu/alu_shift.sv
alu/alu_logic_cmp.sv
alu/alu.sv
rtl/exec_ctrl.sv
rtl/int_exec_unit.sv
bench/tb_int_exec_unit.sv

/* rtl/exec_ctrl.sv */
`timescale 1ns/1ps
`default_nettype none
`include "exec_config.svh"

module exec_ctrl (
    input  wire                    clk_i,
    input  wire                    rst_n_i,
    input  wire                    wb_cyc_i,
    input  wire                    wb_stb_i,
    input  wire                    wb_we_i,
    input  wire  [`EXEC_ADR_W-1:0] wb_adr_i,
    input  wire  [`EXEC_XLEN-1:0]  wb_dat_i,
    output logic [`EXEC_XLEN-1:0]  wb_dat_o,
    output logic                   wb_ack_o,
    output logic [`EXEC_XLEN-1:0]  op_a_o,
    output logic [`EXEC_XLEN-1:0]  op_b_o,
    output exec_pkg::alu_op_e      op_o,
    input  wire  [`EXEC_XLEN-1:0]  alu_result_i,
    input  wire                    alu_illegal_i
);

    logic                  ack_q;
    logic                  req;          // New access, not yet acked
    logic                  wr_req;
    logic [`EXEC_XLEN-1:0] rs1_q;
    logic [`EXEC_XLEN-1:0] rs2_q;
    logic [`EXEC_XLEN-1:0] result_q;
    logic [`EXEC_XLEN-1:0] dat_q;
    logic [`EXEC_XLEN-1:0] rd_data;
    logic [`EXEC_XLEN-1:0] status_w;
    logic                  done_q;
    logic                  illegal_q;
    exec_pkg::alu_op_e     op_q;
    exec_pkg::ctrl_state_e state_q;

    assign req    = wb_cyc_i & wb_stb_i & ~ack_q;
    assign wr_req = req & wb_we_i;

    always_comb begin
        status_w = '0;
        status_w[exec_pkg::STAT_DONE_BIT]    = done_q;
        status_w[exec_pkg::STAT_ILLEGAL_BIT] = illegal_q;
    end

    // Read decode, unmapped reads give zero
    always_comb begin
        case (wb_adr_i)
            `EXEC_REG_RS1:    rd_data = rs1_q;
            `EXEC_REG_RS2:    rd_data = rs2_q;
            `EXEC_REG_CMD:    rd_data = {{(`EXEC_XLEN-4){1'b0}}, op_q};
            `EXEC_REG_STATUS: rd_data = status_w;
            `EXEC_REG_RESULT: rd_data = result_q;
            default:          rd_data = '0;
        endcase
    end

    // ----------------------------------------
    // Bus response, one-cycle ack
    // ----------------------------------------
    always_ff @(posedge clk_i) begin
        if (!rst_n_i) begin
            ack_q <= 1'b0;
            dat_q <= '0;
        end else begin
            ack_q <= req;
            if (req && !wb_we_i) begin
                dat_q <= rd_data;
            end
        end
    end

    // ----------------------------------------
    // Registers and execution FSM
    // ----------------------------------------
    always_ff @(posedge clk_i) begin
        if (!rst_n_i) begin
            rs1_q     <= '0;
            rs2_q     <= '0;
            result_q  <= '0;
            op_q      <= exec_pkg::OP_ADD;
            done_q    <= 1'b0;
            illegal_q <= 1'b0;
            state_q   <= exec_pkg::ST_IDLE;
        end else begin
            if (wr_req && wb_adr_i == `EXEC_REG_RS1) rs1_q <= wb_dat_i;
            if (wr_req && wb_adr_i == `EXEC_REG_RS2) rs2_q <= wb_dat_i;
            case (state_q)
                exec_pkg::ST_IDLE: begin
                    if (wr_req && wb_adr_i == `EXEC_REG_CMD) begin
                        op_q    <= exec_pkg::alu_op_e'(wb_dat_i[3:0]);
                        done_q  <= 1'b0;
                        state_q <= exec_pkg::ST_EXEC;
                    end else if (wr_req && wb_adr_i == `EXEC_REG_STATUS) begin
                        done_q <= 1'b0;    // Software acknowledge
                    end
                end
                exec_pkg::ST_EXEC: begin
                    result_q  <= alu_result_i;
                    illegal_q <= alu_illegal_i;
                    done_q    <= 1'b1;
                    state_q   <= exec_pkg::ST_IDLE;
                end
                default: state_q <= exec_pkg::ST_IDLE;
            endcase
        end
    end

    assign wb_ack_o = ack_q;
    assign wb_dat_o = dat_q;
    assign op_a_o   = rs1_q;
    assign op_b_o   = rs2_q;
    assign op_o     = op_q;

    // Ack answers a request seen on the previous edge
    assert property (@(posedge clk_i) disable iff (!rst_n_i)
        wb_ack_o |-> $past(wb_cyc_i && wb_stb_i))
        else $error("exec_ctrl: ack without a request");

    assert property (@(posedge clk_i) disable iff (!rst_n_i)
        wb_ack_o |=> !wb_ack_o)
        else $error("exec_ctrl: ack held for two cycles");

    assert property (@(posedge clk_i) disable iff (!rst_n_i)
        state_q == exec_pkg::ST_EXEC |=> state_q == exec_pkg::ST_IDLE)
        else $error("exec_ctrl: execute state longer than one cycle");

endmodule

`default_nettype wire

/* rtl/int_exec_unit.sv */
`timescale 1ns/1ps
`default_nettype none
`include "exec_config.svh"

module int_exec_unit (
    input  wire                    clk_i,
    input  wire                    rst_n_i,
    input  wire                    wb_cyc_i,
    input  wire                    wb_stb_i,
    input  wire                    wb_we_i,
    input  wire  [`EXEC_ADR_W-1:0] wb_adr_i,
    input  wire  [`EXEC_XLEN-1:0]  wb_dat_i,
    output logic [`EXEC_XLEN-1:0]  wb_dat_o,
    output logic                   wb_ack_o
);

    // ----------------------------------------
    // Controller to ALU
    // ----------------------------------------
    logic [`EXEC_XLEN-1:0] op_a;
    logic [`EXEC_XLEN-1:0] op_b;
    exec_pkg::alu_op_e     op;
    logic [`EXEC_XLEN-1:0] alu_result;    // Combinational, captured in ST_EXEC
    logic                  alu_illegal;

    exec_ctrl exec_ctrl_inst (
        .clk_i         (clk_i),
        .rst_n_i       (rst_n_i),
        .wb_cyc_i      (wb_cyc_i),
        .wb_stb_i      (wb_stb_i),
        .wb_we_i       (wb_we_i),
        .wb_adr_i      (wb_adr_i),
        .wb_dat_i      (wb_dat_i),
        .wb_dat_o      (wb_dat_o),
        .wb_ack_o      (wb_ack_o),
        .op_a_o        (op_a),
        .op_b_o        (op_b),
        .op_o          (op),
        .alu_result_i  (alu_result),
        .alu_illegal_i (alu_illegal)
    );

    alu alu_inst (
        .op_a_i    (op_a),
        .op_b_i    (op_b),
        .op_i      (op),
        .result_o  (alu_result),
        .illegal_o (alu_illegal)
    );

endmodule

`default_nettype wire

/* run_sim.sh */
#!/usr/bin/env bash
# Build and run the integer execution unit testbench with Verilator
set -u

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -j 0 \
    -f int_exec_unit.f \
    --top-module tb_int_exec_unit \
    -o tb_int_exec_unit
build_status=$?
if [ "$build_status" -ne 0 ]; then
    echo "Verilator build returned status $build_status"
    exit 1
fi

sim_output=$(./obj_dir/tb_int_exec_unit)
sim_status=$?
echo "$sim_output"
if [ "$sim_status" -ne 0 ]; then
    echo "Simulation returned status $sim_status"
    exit 1
fi

if echo "$sim_output" | grep -q -x -F "Testbench passed"; then
    exit 0
fi
exit 1
